/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module portalBridgeTb \
		-f portalBridge.f

run: compile
	./obj_dir/VportalBridgeTb > run.log 2>&1; cat run.log
	grep -q "Regression passed" run.log

clean:
	rm -rf obj_dir run.log

/* logic/burstSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "portal_settings.svh"

module burstSequencer (
  input wire CLK,
  input wire nRST,
  input wire arValid,
  input wire [31:0] arAddr,
  input wire [3:0] arLen,
  input wire [`PORTAL_ID_WIDTH-1:0] arId,
  input wire awValid,
  input wire [31:0] awAddr,
  input wire [3:0] awLen,
  input wire [`PORTAL_ID_WIDTH-1:0] awId,
  input wire wValid,
  input wire [`PORTAL_DATA_WIDTH-1:0] wData,
  input wire [`PORTAL_CHANNELS-1:0] beatReady,
  output logic arReady,
  output logic awReady,
  output logic wReady,
  output logic [`PORTAL_CHANNELS-1:0] beatValid,
  output portalPkg::beatOp_e beatOp,
  output logic [4:0] beatOffset,
  output logic [`PORTAL_DATA_WIDTH-1:0] beatData,
  output logic [`PORTAL_ID_WIDTH-1:0] beatId,
  output logic beatLast
);
  import portalPkg::*;

  localparam int chanCount = `PORTAL_CHANNELS;
  localparam logic [19:0] chanMask = 20'(chanCount - 1);

  seqState_e state;
  logic preferRead;
  logic arFire;
  logic awFire;
  logic [31:0] hsAddr;
  logic [3:0] hsLen;
  logic [chanCount-1:0] hsHot;
  logic [chanCount-1:0] chanHot;
  logic ctrlPage;
  logic [4:0] count;
  logic offer;
  logic selReady;
  logic beatFire;

  // the side that did not go last wins when both addresses arrive together
  assign arReady = (state == SEQ_IDLE) && (preferRead || !awValid);
  assign awReady = (state == SEQ_IDLE) && (!preferRead || !arValid);
  assign arFire = arValid && arReady;
  assign awFire = awValid && awReady;

  assign hsAddr = arFire ? arAddr : awAddr;
  assign hsLen = arFire ? arLen : awLen;

  // channel select from the address bits above the page field
  always_comb begin
    hsHot = '0;
    for (int i = 0; i < chanCount; i++) begin
      hsHot[i] = (hsAddr[31:12] & chanMask) == 20'(i);
    end
  end

  // a write beat is only offered while W data is present
  assign offer = (state == SEQ_READ) || ((state == SEQ_WRITE) && wValid);
  assign selReady = |(beatReady & chanHot);
  assign beatFire = offer && selReady;

  assign beatValid = chanHot & {chanCount{offer}};
  assign wReady = (state == SEQ_WRITE) && selReady;
  assign beatData = wData;
  assign beatLast = count == 5'd1;

  always_comb begin
    case (state)
      SEQ_READ: beatOp = ctrlPage ? OP_CTRL_READ : OP_DATA_READ;
      SEQ_WRITE: beatOp = ctrlPage ? OP_CTRL_WRITE : OP_DATA_WRITE;
      default: beatOp = OP_CTRL_READ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      state <= SEQ_IDLE;
      preferRead <= 1'b1;
    end else begin
      if (arFire) begin
        state <= SEQ_READ;
        preferRead <= 1'b0;
      end else if (awFire) begin
        state <= SEQ_WRITE;
        preferRead <= 1'b1;
      end else if (beatFire && beatLast) begin
        state <= SEQ_IDLE;
      end
    end
  end

  // burst context, loaded on the address handshake and stepped per beat
  always_ff @(posedge CLK) begin
    if (arFire || awFire) begin
      chanHot <= hsHot;
      ctrlPage <= hsAddr[11:5] == 7'd0;
      beatOffset <= hsAddr[4:0];
      count <= {1'b0, hsLen} + 5'd1;
      beatId <= arFire ? arId : awId;
    end else if (beatFire) begin
      // offset wraps inside the 32-byte window
      beatOffset <= beatOffset + 5'd4;
      count <= count - 5'd1;
    end
  end

endmodule

`default_nettype wire

/* logic/portalBridgeTop.sv */
`timescale 1ns/1ns
`default_nettype none

`include "portal_settings.svh"

module portalBridgeTop (
  input wire CLK,
  input wire nRST,
  input wire arValid,
  output logic arReady,
  input wire [31:0] arAddr,
  input wire [3:0] arLen,
  input wire [`PORTAL_ID_WIDTH-1:0] arId,
  input wire awValid,
  output logic awReady,
  input wire [31:0] awAddr,
  input wire [3:0] awLen,
  input wire [`PORTAL_ID_WIDTH-1:0] awId,
  input wire wValid,
  output logic wReady,
  input wire [`PORTAL_DATA_WIDTH-1:0] wData,
  input wire wLast,
  output logic rValid,
  input wire rReady,
  output logic [`PORTAL_DATA_WIDTH-1:0] rData,
  output logic [`PORTAL_ID_WIDTH-1:0] rId,
  output logic rLast,
  output logic bValid,
  input wire bReady,
  output logic [`PORTAL_ID_WIDTH-1:0] bId,
  output logic [`PORTAL_CHANNELS-1:0] interrupt
);
  import portalPkg::*;

  localparam int chanCount = `PORTAL_CHANNELS;
  localparam int dw = `PORTAL_DATA_WIDTH;
  localparam int iw = `PORTAL_ID_WIDTH;

  logic [chanCount-1:0] beatValid;
  logic [chanCount-1:0] beatReady;
  beatOp_e beatOp;
  logic [4:0] beatOffset;
  logic [dw-1:0] beatData;
  logic [iw-1:0] beatId;
  logic beatLast;
  logic [chanCount-1:0] respValid;
  logic [chanCount-1:0] respReady;
  logic [chanCount*dw-1:0] respData;
  logic [chanCount*iw-1:0] respId;
  logic [chanCount-1:0] respLast;
  logic [chanCount-1:0] respIsWrite;

  // wLast is not needed, the beat count from AW ends the burst
  burstSequencer i_burstSequencer (
    .CLK(CLK),
    .nRST(nRST),
    .arValid(arValid),
    .arAddr(arAddr),
    .arLen(arLen),
    .arId(arId),
    .awValid(awValid),
    .awAddr(awAddr),
    .awLen(awLen),
    .awId(awId),
    .wValid(wValid),
    .wData(wData),
    .beatReady(beatReady),
    .arReady(arReady),
    .awReady(awReady),
    .wReady(wReady),
    .beatValid(beatValid),
    .beatOp(beatOp),
    .beatOffset(beatOffset),
    .beatData(beatData),
    .beatId(beatId),
    .beatLast(beatLast)
  );

  for (genvar g = 0; g < chanCount; g++) begin : gChannel
    portalChannel #(
      .channelIndex(g)
    ) i_portalChannel (
      .CLK(CLK),
      .nRST(nRST),
      .beatValid(beatValid[g]),
      .beatOp(beatOp),
      .beatOffset(beatOffset),
      .beatData(beatData),
      .beatId(beatId),
      .beatLast(beatLast),
      .respReady(respReady[g]),
      .beatReady(beatReady[g]),
      .respValid(respValid[g]),
      .respData(respData[g*dw +: dw]),
      .respId(respId[g*iw +: iw]),
      .respLast(respLast[g]),
      .respIsWrite(respIsWrite[g]),
      .interrupt(interrupt[g])
    );
  end

  responseArbiter #(
    .channels(chanCount)
  ) i_responseArbiter (
    .CLK(CLK),
    .nRST(nRST),
    .respValid(respValid),
    .respData(respData),
    .respId(respId),
    .respLast(respLast),
    .respIsWrite(respIsWrite),
    .rReady(rReady),
    .bReady(bReady),
    .respReady(respReady),
    .rValid(rValid),
    .rData(rData),
    .rId(rId),
    .rLast(rLast),
    .bValid(bValid),
    .bId(bId)
  );

endmodule

`default_nettype wire

/* logic/portalChannel.sv */
`timescale 1ns/1ns
`default_nettype none

`include "portal_settings.svh"

module portalChannel #(
  parameter int channelIndex = 0
) (
  input wire CLK,
  input wire nRST,
  input wire beatValid,
  input wire portalPkg::beatOp_e beatOp,
  input wire [4:0] beatOffset,
  input wire [`PORTAL_DATA_WIDTH-1:0] beatData,
  input wire [`PORTAL_ID_WIDTH-1:0] beatId,
  input wire beatLast,
  input wire respReady,
  output logic beatReady,
  output logic respValid,
  output logic [`PORTAL_DATA_WIDTH-1:0] respData,
  output logic [`PORTAL_ID_WIDTH-1:0] respId,
  output logic respLast,
  output logic respIsWrite,
  output logic interrupt
);
  import portalPkg::*;

  localparam int dataWidth = `PORTAL_DATA_WIDTH;
  localparam int depth = `PORTAL_FIFO_DEPTH;
  localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntBits = $clog2(depth + 1);

  logic [dataWidth-1:0] msgMem [depth];
  logic [ptrBits-1:0] wrPtr;
  logic [ptrBits-1:0] rdPtr;
  logic [cntBits-1:0] used;
  logic intEnable;
  logic fifoEmpty;
  logic fifoFull;
  logic beatFire;
  logic isWrite;
  logic wantResp;
  logic doPush;
  logic doPop;
  logic [dataWidth-1:0] readValue;

  function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
    return (ptr == ptrBits'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fifoEmpty = used == '0;
  assign fifoFull = used == cntBits'(depth);
  assign beatReady = !respValid || respReady;
  assign beatFire = beatValid && beatReady;
  assign isWrite = (beatOp == OP_CTRL_WRITE) || (beatOp == OP_DATA_WRITE);
  // writes only answer once, on the closing beat
  assign wantResp = !isWrite || beatLast;
  assign doPush = beatFire && (beatOp == OP_DATA_WRITE) && (beatOffset == 5'h00) && !fifoFull;
  assign doPop = beatFire && (beatOp == OP_DATA_READ) && (beatOffset == 5'h00) && !fifoEmpty;
  assign interrupt = intEnable && !fifoEmpty;

  always_comb begin
    readValue = '0;
    if (beatOp == OP_CTRL_READ) begin
      case (beatOffset)
        5'h00: readValue = dataWidth'(!fifoEmpty);
        5'h04: readValue = dataWidth'(intEnable);
        5'h08: readValue = dataWidth'(cntBits'(depth) - used);
        5'h0C: readValue = dataWidth'(channelIndex);
        default: readValue = '0;
      endcase
    end else if (beatOp == OP_DATA_READ) begin
      if ((beatOffset == 5'h00) && !fifoEmpty) begin
        readValue = msgMem[rdPtr];
      end else if (beatOffset == 5'h04) begin
        readValue = dataWidth'(!fifoFull);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intEnable <= 1'b0;
      wrPtr <= '0;
      rdPtr <= '0;
      used <= '0;
      respValid <= 1'b0;
    end else begin
      if (beatFire && (beatOp == OP_CTRL_WRITE) && (beatOffset == 5'h04)) begin
        intEnable <= beatData[0];
      end
      if (doPush) begin
        wrPtr <= nextPtr(wrPtr);
        used <= used + 1'b1;
      end else if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
        used <= used - 1'b1;
      end
      if (beatFire && wantResp) begin
        respValid <= 1'b1;
      end else if (respReady) begin
        respValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) begin
      msgMem[wrPtr] <= beatData;
    end
    if (beatFire && wantResp) begin
      respData <= readValue;
      respId <= beatId;
      respLast <= beatLast;
      respIsWrite <= isWrite;
    end
  end

endmodule

`default_nettype wire

/* logic/portalPkg.sv */
`default_nettype none

package portalPkg;

  // kind of single-word access handed to a channel
  typedef enum logic [1:0] {
    OP_CTRL_READ  = 2'b00,
    OP_CTRL_WRITE = 2'b01,
    OP_DATA_READ  = 2'b10,
    OP_DATA_WRITE = 2'b11
  } beatOp_e;

  // burst sequencer state, one burst in flight at a time
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'b00,
    SEQ_READ  = 2'b01,
    SEQ_WRITE = 2'b10
  } seqState_e;

endpackage

`default_nettype wire

/* logic/portal_settings.svh */
`ifndef PORTAL_SETTINGS_SVH
`define PORTAL_SETTINGS_SVH

// number of portal channels, a power of two from 1 to 8
`define PORTAL_CHANNELS 2

// message FIFO depth per channel, a power of two
`define PORTAL_FIFO_DEPTH 4

// bus field widths
`define PORTAL_ID_WIDTH 6
`define PORTAL_DATA_WIDTH 32

`endif

/* logic/responseArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "portal_settings.svh"

module responseArbiter #(
  parameter int channels = 1
) (
  input wire CLK,
  input wire nRST,
  input wire [channels-1:0] respValid,
  input wire [channels*`PORTAL_DATA_WIDTH-1:0] respData,
  input wire [channels*`PORTAL_ID_WIDTH-1:0] respId,
  input wire [channels-1:0] respLast,
  input wire [channels-1:0] respIsWrite,
  input wire rReady,
  input wire bReady,
  output logic [channels-1:0] respReady,
  output logic rValid,
  output logic [`PORTAL_DATA_WIDTH-1:0] rData,
  output logic [`PORTAL_ID_WIDTH-1:0] rId,
  output logic rLast,
  output logic bValid,
  output logic [`PORTAL_ID_WIDTH-1:0] bId
);
  localparam int dw = `PORTAL_DATA_WIDTH;
  localparam int iw = `PORTAL_ID_WIDTH;

  logic [channels-1:0] grant;
  logic found;
  logic take;
  logic rFree;
  logic bFree;
  logic [dw-1:0] selData;
  logic [iw-1:0] selId;
  logic selLast;
  logic selIsWrite;

  // lowest index wins
  always_comb begin
    grant = '0;
    found = 1'b0;
    selData = '0;
    selId = '0;
    selLast = 1'b0;
    selIsWrite = 1'b0;
    for (int i = 0; i < channels; i++) begin
      if (respValid[i] && !found) begin
        found = 1'b1;
        grant[i] = 1'b1;
        selData = respData[i*dw +: dw];
        selId = respId[i*iw +: iw];
        selLast = respLast[i];
        selIsWrite = respIsWrite[i];
      end
    end
  end

  assign rFree = !rValid || rReady;
  assign bFree = !bValid || bReady;
  assign take = found && (selIsWrite ? bFree : rFree);
  assign respReady = grant & {channels{take}};

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      rValid <= 1'b0;
      bValid <= 1'b0;
    end else begin
      if (take && !selIsWrite) begin
        rValid <= 1'b1;
      end else if (rReady) begin
        rValid <= 1'b0;
      end
      if (take && selIsWrite) begin
        bValid <= 1'b1;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (take && !selIsWrite) begin
      rData <= selData;
      rId <= selId;
      rLast <= selLast;
    end
    if (take && selIsWrite) begin
      bId <= selId;
    end
  end

endmodule

`default_nettype wire

/* portalBridge.f */
+incdir+logic
logic/portalPkg.sv
logic/burstSequencer.sv
logic/portalChannel.sv
logic/responseArbiter.sv
logic/portalBridgeTop.sv
verification/portalBridgeTb.sv

/* verification/portalBridgeTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "portal_settings.svh"

module portalBridgeTb;
  localparam int chanCount = `PORTAL_CHANNELS;
  localparam int depth = `PORTAL_FIFO_DEPTH;
  localparam int cycleLimit = 4000;

  logic CLK;
  logic nRST;
  logic arValid;
  logic arReady;
  logic [31:0] arAddr;
  logic [3:0] arLen;
  logic [5:0] arId;
  logic awValid;
  logic awReady;
  logic [31:0] awAddr;
  logic [3:0] awLen;
  logic [5:0] awId;
  logic wValid;
  logic wReady;
  logic [31:0] wData;
  logic wLast;
  logic rValid;
  logic rReady;
  logic [31:0] rData;
  logic [5:0] rId;
  logic rLast;
  logic bValid;
  logic bReady;
  logic [5:0] bId;
  logic [chanCount-1:0] interrupt;

  // expected responses kept in issue order and consumed at each handshake
  logic [31:0] expRData [256];
  logic [5:0] expRId [256];
  logic expRLast [256];
  logic [5:0] expBId [256];
  int rPushed = 0;
  int rSeen = 0;
  int bPushed = 0;
  int bSeen = 0;

  // reference model with one word queue and one enable bit per channel
  logic [31:0] modelFifo [chanCount][depth];
  int modelUsed [chanCount];
  logic modelIntEn [chanCount];

  logic [31:0] dataSeed;
  logic [31:0] stallSeed;
  logic stallOn;
  logic [31:0] wordBuf [16];
  int errors = 0;
  int testCount = 0;
  int testFails = 0;
  int cycles = 0;

  portalBridgeTop i_portalBridgeTop (
    .CLK(CLK),
    .nRST(nRST),
    .arValid(arValid),
    .arReady(arReady),
    .arAddr(arAddr),
    .arLen(arLen),
    .arId(arId),
    .awValid(awValid),
    .awReady(awReady),
    .awAddr(awAddr),
    .awLen(awLen),
    .awId(awId),
    .wValid(wValid),
    .wReady(wReady),
    .wData(wData),
    .wLast(wLast),
    .rValid(rValid),
    .rReady(rReady),
    .rData(rData),
    .rId(rId),
    .rLast(rLast),
    .bValid(bValid),
    .bReady(bReady),
    .bId(bId),
    .interrupt(interrupt)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic expectValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else reportMismatch(name, got, exp);
  endtask

  // random ready stalls while stallOn is set
  always @(negedge CLK) begin
    stallSeed = xorshift(stallSeed);
    rReady = stallOn ? stallSeed[3] : 1'b1;
    bReady = stallOn ? stallSeed[9] : 1'b1;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  always @(posedge CLK) begin
    if (nRST && rValid && rReady) begin
      rSeen <= rSeen + 1;
    end
    if (nRST && bValid && bReady) begin
      bSeen <= bSeen + 1;
    end
  end

  rExtraCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (rValid && rReady) |-> (rSeen < rPushed))
    else begin
      $display("Unexpected R response at %0t ns with rId %0d", $time, $sampled(rId));
      errors++;
    end
  rDataCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (rValid && rReady && rSeen < rPushed) |-> (rData == expRData[rSeen]))
    else reportMismatch("rData", $sampled(rData), expRData[$sampled(rSeen)]);
  rIdCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (rValid && rReady && rSeen < rPushed) |-> (rId == expRId[rSeen]))
    else reportMismatch("rId", 32'($sampled(rId)), 32'(expRId[$sampled(rSeen)]));
  rLastCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (rValid && rReady && rSeen < rPushed) |-> (rLast == expRLast[rSeen]))
    else reportMismatch("rLast", 32'($sampled(rLast)), 32'(expRLast[$sampled(rSeen)]));
  bExtraCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (bValid && bReady) |-> (bSeen < bPushed))
    else begin
      $display("Unexpected B response at %0t ns with bId %0d", $time, $sampled(bId));
      errors++;
    end
  bIdCheck: assert property (@(posedge CLK) disable iff (!nRST)
      (bValid && bReady && bSeen < bPushed) |-> (bId == expBId[bSeen]))
    else reportMismatch("bId", 32'($sampled(bId)), 32'(expBId[$sampled(bSeen)]));

  function automatic logic [31:0] busAddr(input int ch, input logic ctrl,
                                          input logic [4:0] off);
    // the control page is page 0 and the data page is page 1
    return (32'(ch) << 12) | (ctrl ? 32'h0 : 32'h20) | 32'(off);
  endfunction

  function automatic logic [31:0] modelRead(input int ch, input logic ctrl,
                                            input logic [4:0] off);
    logic [31:0] v;
    v = '0;
    if (ctrl) begin
      case (off)
        5'h00: v = 32'(modelUsed[ch] != 0);
        5'h04: v = 32'(modelIntEn[ch]);
        5'h08: v = 32'(depth - modelUsed[ch]);
        5'h0C: v = 32'(ch);
        default: v = '0;
      endcase
    end else if (off == 5'h00 && modelUsed[ch] != 0) begin
      v = modelFifo[ch][0];
      for (int i = 1; i < depth; i++) begin
        modelFifo[ch][i-1] = modelFifo[ch][i];
      end
      modelUsed[ch]--;
    end else if (off == 5'h04) begin
      v = 32'(modelUsed[ch] != depth);
    end
    return v;
  endfunction

  function automatic void modelWrite(input int ch, input logic ctrl, input logic [4:0] off,
                                     input logic [31:0] data);
    if (ctrl && off == 5'h04) begin
      modelIntEn[ch] = data[0];
    end else if (!ctrl && off == 5'h00 && modelUsed[ch] < depth) begin
      modelFifo[ch][modelUsed[ch]] = data;
      modelUsed[ch]++;
    end
  endfunction

  function automatic logic [chanCount-1:0] modelInterrupts();
    logic [chanCount-1:0] v;
    for (int c = 0; c < chanCount; c++) begin
      v[c] = modelIntEn[c] && (modelUsed[c] != 0);
    end
    return v;
  endfunction

  task automatic fillWords(input int n);
    for (int i = 0; i < n; i++) begin
      dataSeed = xorshift(dataSeed);
      wordBuf[i] = dataSeed;
    end
  endtask

  task automatic readBurst(input int ch, input logic ctrl, input logic [4:0] start,
                           input int len, input logic [5:0] id);
    logic [4:0] off;
    off = start;
    for (int i = 0; i < len; i++) begin
      expRData[rPushed] = modelRead(ch, ctrl, off);
      expRId[rPushed] = id;
      expRLast[rPushed] = (i == len - 1);
      rPushed++;
      off = off + 5'd4;
    end
    @(negedge CLK);
    arValid = 1'b1;
    arAddr = busAddr(ch, ctrl, start);
    arLen = 4'(len - 1);
    arId = id;
    @(posedge CLK);
    while (!arReady) @(posedge CLK);
    @(negedge CLK);
    arValid = 1'b0;
    while (rSeen != rPushed) @(negedge CLK);
  endtask

  task automatic writeBurst(input int ch, input logic ctrl, input logic [4:0] start,
                            input int len, input logic [5:0] id);
    logic [4:0] off;
    off = start;
    for (int i = 0; i < len; i++) begin
      modelWrite(ch, ctrl, off, wordBuf[i]);
      off = off + 5'd4;
    end
    expBId[bPushed] = id;
    bPushed++;
    @(negedge CLK);
    awValid = 1'b1;
    awAddr = busAddr(ch, ctrl, start);
    awLen = 4'(len - 1);
    awId = id;
    @(posedge CLK);
    while (!awReady) @(posedge CLK);
    @(negedge CLK);
    awValid = 1'b0;
    for (int i = 0; i < len; i++) begin
      wValid = 1'b1;
      wData = wordBuf[i];
      wLast = (i == len - 1);
      @(posedge CLK);
      while (!wReady) @(posedge CLK);
      @(negedge CLK);
    end
    wValid = 1'b0;
    wLast = 1'b0;
    while (bSeen != bPushed) @(negedge CLK);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCount++;
    if (errors == errBefore) begin
      $display("test %0d %s: ok", testCount, name);
    end else begin
      testFails++;
      $display("test %0d %s: %0d errors", testCount, name, errors - errBefore);
    end
  endtask

  initial begin
    int mark;
    nRST = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    wLast = 1'b0;
    rReady = 1'b1;
    bReady = 1'b1;
    stallOn = 1'b0;
    dataSeed = 32'd52286;
    stallSeed = xorshift(32'd52286);
    for (int c = 0; c < chanCount; c++) begin
      modelUsed[c] = 0;
      modelIntEn[c] = 1'b0;
    end
    repeat (8) @(negedge CLK);
    nRST = 1'b1;

    mark = errors;
    @(negedge CLK);
    expectValue("rValid", 32'(rValid), 32'd0);
    expectValue("bValid", 32'(bValid), 32'd0);
    expectValue("interrupt", 32'(interrupt), 32'd0);
    expectValue("arReady", 32'(arReady), 32'd1);
    expectValue("awReady", 32'(awReady), 32'd1);
    finishTest("reset state", mark);

    mark = errors;
    for (int c = 0; c < chanCount; c++) begin
      readBurst(c, 1'b1, 5'h00, 5, 6'(c + 1));
    end
    finishTest("control map", mark);

    // the offset 4 beat of each two-beat write pushes nothing
    mark = errors;
    for (int k = 0; k < 3; k++) begin
      fillWords(2);
      writeBurst(0, 1'b0, 5'h00, 2, 6'(8 + k));
    end
    for (int k = 0; k < 2; k++) begin
      fillWords(1);
      writeBurst(1, 1'b0, 5'h00, 1, 6'(12 + k));
    end
    readBurst(1, 1'b0, 5'h04, 1, 6'd14);
    for (int k = 0; k < 4; k++) begin
      readBurst(0, 1'b0, 5'h00, 1, 6'(16 + k));
    end
    for (int k = 0; k < 3; k++) begin
      readBurst(1, 1'b0, 5'h00, 1, 6'(20 + k));
    end
    finishTest("message echo and isolation", mark);

    mark = errors;
    for (int k = 0; k < depth + 2; k++) begin
      fillWords(1);
      writeBurst(1, 1'b0, 5'h00, 1, 6'(24 + k));
    end
    readBurst(1, 1'b1, 5'h08, 1, 6'd30);
    readBurst(1, 1'b0, 5'h04, 1, 6'd31);
    for (int k = 0; k < depth + 1; k++) begin
      readBurst(1, 1'b0, 5'h00, 1, 6'(32 + k));
    end
    finishTest("overflow drop", mark);

    mark = errors;
    wordBuf[0] = 32'd1;
    writeBurst(0, 1'b1, 5'h04, 1, 6'd40);
    expectValue("interrupt", 32'(interrupt), 32'(modelInterrupts()));
    fillWords(1);
    writeBurst(0, 1'b0, 5'h00, 1, 6'd41);
    expectValue("interrupt", 32'(interrupt), 32'(modelInterrupts()));
    readBurst(0, 1'b0, 5'h00, 1, 6'd42);
    expectValue("interrupt", 32'(interrupt), 32'(modelInterrupts()));
    finishTest("interrupt", mark);

    mark = errors;
    stallOn = 1'b1;
    fillWords(1);
    writeBurst(0, 1'b0, 5'h00, 1, 6'd43);
    // wraps 0x18, 0x1C, 0x00, 0x04
    readBurst(0, 1'b1, 5'h18, 4, 6'd44);
    fillWords(3);
    writeBurst(1, 1'b0, 5'h00, 3, 6'd45);
    readBurst(0, 1'b0, 5'h00, 9, 6'd46);
    readBurst(1, 1'b0, 5'h00, 1, 6'd47);
    stallOn = 1'b0;
    repeat (4) @(negedge CLK);
    expectValue("rValid", 32'(rValid), 32'd0);
    expectValue("bValid", 32'(bValid), 32'd0);
    finishTest("burst wrap under back-pressure", mark);

    $display("%0d tests, %0d failed, %0d check errors", testCount, testFails, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
